//--- design/cl_glue_pkg.sv
// ------------------------------------------------
// Shared types and defaults for the shell glue logic
// Imported by every RTL block of the design
// ------------------------------------------------

package cl_glue_pkg;

   // ------------------------------------------------
   // Defaults, overridden through top level parameters
   // ------------------------------------------------
   localparam int NUM_DDR         = 4;      // DDR channels A, B, C, D
   localparam int DEF_STAT_STAGES = 8;      // Stats pipe depth across the die

   // PCIe IDs, upper half device/subsystem, lower half vendor
   localparam logic [31:0] DEF_CL_ID0 = 32'h0F00_1234;
   localparam logic [31:0] DEF_CL_ID1 = 32'h0001_1234;

   // ------------------------------------------------
   // DDR statistics bus
   // ------------------------------------------------
   typedef struct packed {
      logic        wr;                      // Stats register write
      logic        rd;                      // Stats register read
      logic [7:0]  addr;                    // Stats register address
      logic [31:0] wdata;
   } stat_req_t;                            // 42 bits

   typedef struct packed {
      logic        ack;                     // Access done
      logic [7:0]  int_vec;                 // Interrupt vector from controller
      logic [31:0] rdata;
   } stat_rsp_t;                            // 41 bits

   // Result of the status synchronizer
   typedef struct packed {
      logic [NUM_DDR-1:0] ddr_ready;        // Bit 0 is channel A
      logic               flr_pending;      // Registered FLR assert
      logic [15:0]        flr_count;        // FLR requests seen, saturating
   } status_t;                              // 21 bits

   // ------------------------------------------------
   // OCL port encodings
   // ------------------------------------------------
   typedef enum logic [1:0] {
      resp_okay   = 2'b00,
      resp_slverr = 2'b10
   } axi_resp_e;

   typedef enum logic [7:0] {
      reg_id0       = 8'h00,
      reg_id1       = 8'h04,
      reg_status    = 8'h08,
      reg_flr_count = 8'h0C,
      reg_stat_acks = 8'h10,
      reg_scratch   = 8'h14
   } reg_addr_e;

endpackage

//--- design/status_sync.sv
// ------------------------------------------------
// FLR handshake with the shell and DDR ready sync
// Result goes to the OCL register block as status_t
// ------------------------------------------------
`timescale 1ns/10ps

module status_sync import cl_glue_pkg::*;
(
   input  logic               clk_main_a0,
   input  logic               sync_rst_n,
   input  logic               sh_cl_flr_assert,
   output logic               cl_sh_flr_done,
   input  logic [NUM_DDR-1:0] ddr_is_ready,
   output status_t            status
);

   logic               flr_q;               // Sampled FLR request
   logic               flr_qq;              // For edge detect
   logic [15:0]        flr_count;
   logic [NUM_DDR-1:0] ddr_meta;            // First sync stage
   logic [NUM_DDR-1:0] ddr_sync;            // Second sync stage

   // ------------------------------------------------
   // FLR acknowledge and request counter
   // ------------------------------------------------
   always_ff @(posedge clk_main_a0 or negedge sync_rst_n)
   begin
      if (!sync_rst_n)
      begin
         flr_q          <= 1'b0;
         flr_qq         <= 1'b0;
         cl_sh_flr_done <= 1'b0;
         flr_count      <= '0;
      end
      else
      begin
         flr_q  <= sh_cl_flr_assert;
         flr_qq <= flr_q;
         // Done rises two clocks after the shell raises assert, then toggles
         cl_sh_flr_done <= flr_q && !cl_sh_flr_done;
         if (flr_q && !flr_qq && (flr_count != 16'hFFFF))
            flr_count <= flr_count + 16'd1;  // One per new request, saturates
      end
   end

   // ------------------------------------------------
   // DDR ready, two flop synchronizer
   // ------------------------------------------------
   always_ff @(posedge clk_main_a0 or negedge sync_rst_n)
   begin
      if (!sync_rst_n)
      begin
         ddr_meta <= '0;
         ddr_sync <= '0;
      end
      else
      begin
         ddr_meta <= ddr_is_ready;
         ddr_sync <= ddr_meta;
      end
   end

   assign status.ddr_ready   = ddr_sync;
   assign status.flr_pending = flr_q;
   assign status.flr_count   = flr_count;

endmodule

//--- design/stat_pipe.sv
// ------------------------------------------------
// Register pipelines for DDR stats across the die
// Requests go out and responses come back, equal depth
// ------------------------------------------------
`timescale 1ns/10ps

module stat_pipe import cl_glue_pkg::*;
#(
   parameter int STAT_STAGES = DEF_STAT_STAGES   // Depth each way, at least 1
)
(
   input  logic        clk_main_a0,
   input  logic        sync_rst_n,
   input  stat_req_t   stat_req,                 // From shell
   output stat_req_t   stat_req_q,               // Toward DDR controller
   input  stat_rsp_t   stat_rsp,                 // From DDR controller
   output stat_rsp_t   stat_rsp_q,               // Back to shell
   output logic [15:0] stat_ack_count
);

   stat_req_t req_stage [STAT_STAGES];
   stat_rsp_t rsp_stage [STAT_STAGES];

   // ------------------------------------------------
   // Delay chains, both directions share one stage body
   // ------------------------------------------------
   for (genvar i = 0; i < STAT_STAGES; i++)
   begin : g_stage
      stat_req_t req_prev;
      stat_rsp_t rsp_prev;

      if (i == 0)
      begin : g_first
         assign req_prev = stat_req;             // Head of chain
         assign rsp_prev = stat_rsp;
      end
      else
      begin : g_next
         assign req_prev = req_stage[i-1];
         assign rsp_prev = rsp_stage[i-1];
      end

      // Whole stage cleared so no stray wr, rd or ack after reset
      always_ff @(posedge clk_main_a0 or negedge sync_rst_n)
      begin
         if (!sync_rst_n)
         begin
            req_stage[i] <= '0;
            rsp_stage[i] <= '0;
         end
         else
         begin
            req_stage[i] <= req_prev;
            rsp_stage[i] <= rsp_prev;
         end
      end
   end

   assign stat_req_q = req_stage[STAT_STAGES-1];
   assign stat_rsp_q = rsp_stage[STAT_STAGES-1];

   // Acks leaving on the shell side
   always_ff @(posedge clk_main_a0 or negedge sync_rst_n)
   begin
      if (!sync_rst_n)
         stat_ack_count <= '0;
      else if (stat_rsp_q.ack && (stat_ack_count != 16'hFFFF))
         stat_ack_count <= stat_ack_count + 16'd1;   // Saturates
   end

endmodule

//--- design/ocl_regs.sv
// ------------------------------------------------
// OCL AXI4-Lite register slave, one access per side
// Reports IDs, status and counts, holds a scratch word
// ------------------------------------------------
`timescale 1ns/10ps

module ocl_regs import cl_glue_pkg::*;
#(
   parameter logic [31:0] CL_ID0 = DEF_CL_ID0,
   parameter logic [31:0] CL_ID1 = DEF_CL_ID1
)
(
   input  logic        clk_main_a0,
   input  logic        sync_rst_n,
   // Write address and data
   input  logic        awvalid,
   input  logic [31:0] awaddr,
   output logic        awready,
   input  logic        wvalid,
   input  logic [31:0] wdata,
   input  logic [3:0]  wstrb,
   output logic        wready,
   // Write response
   output logic        bvalid,
   output axi_resp_e   bresp,
   input  logic        bready,
   // Read address and data
   input  logic        arvalid,
   input  logic [31:0] araddr,
   output logic        arready,
   output logic        rvalid,
   output logic [31:0] rdata,
   output axi_resp_e   rresp,
   input  logic        rready,
   // Register sources
   input  status_t     status,
   input  logic [15:0] stat_ack_count
);

   logic        wr_accept;
   logic        rd_accept;
   reg_addr_e   wr_addr;
   reg_addr_e   rd_addr;
   logic [31:0] scratch;
   logic [31:0] scratch_nxt;
   axi_resp_e   wr_resp_nxt;
   logic [31:0] rd_data_nxt;
   axi_resp_e   rd_resp_nxt;

   // ------------------------------------------------
   // Handshakes, pending response blocks its own side
   // ------------------------------------------------
   assign wr_accept = awvalid && wvalid && !bvalid;
   assign awready   = wr_accept;                 // aw and w taken together
   assign wready    = wr_accept;
   assign rd_accept = arvalid && !rvalid;
   assign arready   = rd_accept;

   // Offsets within the 256 byte window
   assign wr_addr = reg_addr_e'(awaddr[7:0]);
   assign rd_addr = reg_addr_e'(araddr[7:0]);

   // Write decode, only scratch is writable
   always_comb
   begin
      scratch_nxt = scratch;
      wr_resp_nxt = resp_slverr;
      if (wr_addr == reg_scratch)
      begin
         wr_resp_nxt = resp_okay;
         for (int b = 0; b < 4; b++)
            if (wstrb[b])
               scratch_nxt[8*b +: 8] = wdata[8*b +: 8];  // Byte merge
      end
   end

   // Read mux
   always_comb
   begin
      rd_data_nxt = '0;
      rd_resp_nxt = resp_okay;
      case (rd_addr)
         reg_id0       : rd_data_nxt = CL_ID0;
         reg_id1       : rd_data_nxt = CL_ID1;
         reg_status    :
         begin
            rd_data_nxt[NUM_DDR-1:0] = status.ddr_ready;  // Bits 3:0
            rd_data_nxt[8]           = status.flr_pending;
         end
         reg_flr_count : rd_data_nxt[15:0] = status.flr_count;
         reg_stat_acks : rd_data_nxt[15:0] = stat_ack_count;
         reg_scratch   : rd_data_nxt = scratch;
         default       : rd_resp_nxt = resp_slverr;      // Zero data
      endcase
   end

   // ------------------------------------------------
   // Control state
   // ------------------------------------------------
   always_ff @(posedge clk_main_a0 or negedge sync_rst_n)
   begin
      if (!sync_rst_n)
      begin
         bvalid  <= 1'b0;
         rvalid  <= 1'b0;
         scratch <= '0;
      end
      else
      begin
         if (wr_accept)
         begin
            bvalid  <= 1'b1;
            scratch <= scratch_nxt;              // Unchanged on slverr
         end
         else if (bready)
            bvalid <= 1'b0;                      // Held until taken
         if (rd_accept)
            rvalid <= 1'b1;
         else if (rready)
            rvalid <= 1'b0;
      end
   end

   // Response payload, qualified by bvalid and rvalid
   always_ff @(posedge clk_main_a0)
   begin
      if (wr_accept)
         bresp <= wr_resp_nxt;
      if (rd_accept)
      begin
         rdata <= rd_data_nxt;
         rresp <= rd_resp_nxt;
      end
   end

endmodule

//--- design/cl_glue_top.sv
// ------------------------------------------------
// Glue between shell and custom logic, one clock
// Sets the depth and ID parameters for the blocks below
// ------------------------------------------------
`timescale 1ns/10ps

module cl_glue_top import cl_glue_pkg::*;
#(
   parameter int          STAT_STAGES = DEF_STAT_STAGES,
   parameter logic [31:0] CL_ID0      = DEF_CL_ID0,
   parameter logic [31:0] CL_ID1      = DEF_CL_ID1
)
(
   input  logic               clk_main_a0,
   input  logic               sync_rst_n,
   // FLR
   input  logic               sh_cl_flr_assert,
   output logic               cl_sh_flr_done,
   // DDR ready, channel A in bit 0
   input  logic [NUM_DDR-1:0] ddr_is_ready,
   // DDR stats
   input  stat_req_t          stat_req,
   output stat_rsp_t          stat_rsp_q,
   output stat_req_t          stat_req_q,
   input  stat_rsp_t          stat_rsp,
   // OCL AXI4-Lite slave
   input  logic               awvalid,
   input  logic [31:0]        awaddr,
   output logic               awready,
   input  logic               wvalid,
   input  logic [31:0]        wdata,
   input  logic [3:0]         wstrb,
   output logic               wready,
   output logic               bvalid,
   output logic [1:0]         bresp,
   input  logic               bready,
   input  logic               arvalid,
   input  logic [31:0]        araddr,
   output logic               arready,
   output logic               rvalid,
   output logic [31:0]        rdata,
   output logic [1:0]         rresp,
   input  logic               rready
);

   status_t     status;                      // Sync result to regs
   logic [15:0] stat_ack_count;              // Pipe result to regs

   status_sync status_sync_i (
      .clk_main_a0      (clk_main_a0),
      .sync_rst_n       (sync_rst_n),
      .sh_cl_flr_assert (sh_cl_flr_assert),
      .cl_sh_flr_done   (cl_sh_flr_done),
      .ddr_is_ready     (ddr_is_ready),
      .status           (status)
   );

   stat_pipe #(.STAT_STAGES(STAT_STAGES)) stat_pipe_i (
      .clk_main_a0    (clk_main_a0),
      .sync_rst_n     (sync_rst_n),
      .stat_req       (stat_req),
      .stat_req_q     (stat_req_q),
      .stat_rsp       (stat_rsp),
      .stat_rsp_q     (stat_rsp_q),
      .stat_ack_count (stat_ack_count)
   );

   ocl_regs #(.CL_ID0(CL_ID0), .CL_ID1(CL_ID1)) ocl_regs_i (
      .clk_main_a0    (clk_main_a0),
      .sync_rst_n     (sync_rst_n),
      .awvalid        (awvalid),
      .awaddr         (awaddr),
      .awready        (awready),
      .wvalid         (wvalid),
      .wdata          (wdata),
      .wstrb          (wstrb),
      .wready         (wready),
      .bvalid         (bvalid),
      .bresp          (bresp),
      .bready         (bready),
      .arvalid        (arvalid),
      .araddr         (araddr),
      .arready        (arready),
      .rvalid         (rvalid),
      .rdata          (rdata),
      .rresp          (rresp),
      .rready         (rready),
      .status         (status),
      .stat_ack_count (stat_ack_count)
   );

endmodule

//--- tb/cl_glue_props.sv
// ------------------------------------------------
// Bound assertions on OCL handshakes and stats delay
// ------------------------------------------------
`timescale 1ns/10ps

module cl_glue_props import cl_glue_pkg::*;
#(
   parameter int STAT_STAGES = 4
)
(
   input  logic        clk_main_a0,
   input  logic        sync_rst_n,
   input  logic        awvalid,
   input  logic        awready,
   input  logic        wvalid,
   input  logic        wready,
   input  logic        bvalid,
   input  logic        bready,
   input  logic [1:0]  bresp,
   input  logic        arvalid,
   input  logic        arready,
   input  logic        rvalid,
   input  logic        rready,
   input  logic [31:0] rdata,
   input  logic [1:0]  rresp,
   input  stat_req_t   stat_req,
   input  stat_req_t   stat_req_q
);

   int fail_count = 0;                      // Failed assertions so far

   // Responses held until taken
   b_hold: assert property (@(posedge clk_main_a0) disable iff (!sync_rst_n)
      bvalid && !bready |=> bvalid && $stable(bresp))
   else
   begin
      fail_count++;
      $error("bvalid dropped or bresp changed before bready");
   end

   r_hold: assert property (@(posedge clk_main_a0) disable iff (!sync_rst_n)
      rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
   else
   begin
      fail_count++;
      $error("rvalid dropped or read payload changed before rready");
   end

   aw_w_ready: assert property (@(posedge clk_main_a0) disable iff (!sync_rst_n)
      (awready || wready) |-> (awvalid && wvalid))
   else
   begin
      fail_count++;
      $error("awready or wready high without both valids");
   end

   // Read address taken only when offered
   ar_ready: assert property (@(posedge clk_main_a0) disable iff (!sync_rst_n)
      arready |-> arvalid)
   else
   begin
      fail_count++;
      $error("arready high without arvalid");
   end

   // Request pipe depth
   req_delay: assert property (@(posedge clk_main_a0) disable iff (!sync_rst_n)
      stat_req_q == $past(stat_req, STAT_STAGES))
   else
   begin
      fail_count++;
      $error("stat_req_q differs from stat_req of STAT_STAGES cycles ago");
   end

endmodule

//--- tb/tb_checker.sv
// ------------------------------------------------
// Watches the DUT ports and compares every response
// with expectations queued by the stimulus driver
// ------------------------------------------------
`timescale 1ns/10ps

module tb_checker import cl_glue_pkg::*;
#(
   parameter int STAT_STAGES = 4
)
(
   input  logic        clk_main_a0,
   input  logic        sync_rst_n,
   input  logic        sh_cl_flr_assert,
   input  logic        cl_sh_flr_done,
   input  stat_req_t   stat_req,
   input  stat_req_t   stat_req_q,
   input  stat_rsp_t   stat_rsp,
   input  stat_rsp_t   stat_rsp_q,
   input  logic        bvalid,
   input  logic        bready,
   input  logic [1:0]  bresp,
   input  logic        rvalid,
   input  logic        rready,
   input  logic [31:0] rdata,
   input  logic [1:0]  rresp
);

   int          err_count   = 0;
   int          check_count = 0;
   logic [1:0]  wr_resp_q [$];              // Expected bresp, oldest first
   logic [31:0] rd_data_q [$];
   logic [1:0]  rd_resp_q [$];
   stat_req_t   req_hist  [$];              // Last STAT_STAGES inputs
   stat_rsp_t   rsp_hist  [$];
   logic [15:0] hi_run;                     // Edges with assert high
   logic [1:0]  lo_run;                     // Edges with assert low, saturating
   logic        done_exp;
   logic        done_chk;

   task automatic expect_write(input logic [1:0] resp);
      wr_resp_q.push_back(resp);
   endtask

   task automatic expect_read(input logic [31:0] data, input logic [1:0] resp);
      rd_data_q.push_back(data);
      rd_resp_q.push_back(resp);
   endtask

   function automatic int outstanding();
      return wr_resp_q.size() + rd_data_q.size();
   endfunction

   task automatic compare_value(input string name, input logic [63:0] got,
                                input logic [63:0] exp);
      check_count++;
      if (got !== exp)
      begin
         err_count++;
         $display("ERR %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
      end
   endtask

   always @(posedge clk_main_a0)
   begin
      if (!sync_rst_n)
      begin
         req_hist.delete();
         rsp_hist.delete();
         for (int i = 0; i < STAT_STAGES; i++)
         begin
            req_hist.push_back('0);         // Stages clear in reset
            rsp_hist.push_back('0);
         end
         hi_run   = '0;
         lo_run   = '0;
         done_exp = 1'b0;
         done_chk = 1'b0;
      end
      else
      begin
         // ------------------------------------------------
         // FLR done, high 2 clocks after raise then toggling
         // ------------------------------------------------
         if (done_chk)
            compare_value("cl_sh_flr_done", 64'(cl_sh_flr_done), 64'(done_exp));
         if (sh_cl_flr_assert)
         begin
            done_exp = hi_run[0];           // Odd edge count means high
            done_chk = 1'b1;
            hi_run   = hi_run + 16'd1;
            lo_run   = 2'd0;
         end
         else
         begin
            done_exp = 1'b0;
            done_chk = (lo_run != 2'd0);    // Low by the second clock
            if (lo_run != 2'd3)
               lo_run = lo_run + 2'd1;
            hi_run = '0;
         end

         // Stats pipes, fixed delay both ways
         compare_value("stat_req_q", 64'(stat_req_q), 64'(req_hist[0]));
         compare_value("stat_rsp_q", 64'(stat_rsp_q), 64'(rsp_hist[0]));
         void'(req_hist.pop_front());
         void'(rsp_hist.pop_front());
         req_hist.push_back(stat_req);
         rsp_hist.push_back(stat_rsp);

         // OCL responses at their handshake
         if (bvalid && bready)
         begin
            if (wr_resp_q.size() == 0)
            begin
               err_count++;
               $display("Write response arrived with no write outstanding at %0t", $time);
            end
            else
               compare_value("bresp", 64'(bresp), 64'(wr_resp_q.pop_front()));
         end
         if (rvalid && rready)
         begin
            if (rd_data_q.size() == 0)
            begin
               err_count++;
               $display("Read response arrived with no read outstanding at %0t", $time);
            end
            else
            begin
               compare_value("rdata", 64'(rdata), 64'(rd_data_q.pop_front()));
               compare_value("rresp", 64'(rresp), 64'(rd_resp_q.pop_front()));
            end
         end
      end
   end

endmodule

//--- tb/tb_top.sv
// ------------------------------------------------
// Top testbench for the shell glue logic. Runs the
// operations in tb/testdata.txt and prints the verdict
// ------------------------------------------------
`timescale 1ns/10ps

module tb_top
   import cl_glue_pkg::*;
();

   localparam int          CLK_PERIOD = 100;
   localparam int          STAGES     = 4;              // Short pipes for the test
   localparam logic [31:0] TEST_ID0   = 32'hF010_1D0F;  // Device F010 and vendor 1D0F
   localparam logic [31:0] TEST_ID1   = 32'h1D51_FEDC;  // Subsystem IDs

   logic               clk_main_a0;
   logic               sync_rst_n;
   logic               sh_cl_flr_assert;
   logic               cl_sh_flr_done;
   logic [NUM_DDR-1:0] ddr_is_ready;
   stat_req_t          stat_req;
   stat_req_t          stat_req_q;
   stat_rsp_t          stat_rsp;
   stat_rsp_t          stat_rsp_q;
   logic               awvalid;
   logic [31:0]        awaddr;
   logic               awready;
   logic               wvalid;
   logic [31:0]        wdata;
   logic [3:0]         wstrb;
   logic               wready;
   logic               bvalid;
   logic [1:0]         bresp;
   logic               bready;
   logic               arvalid;
   logic [31:0]        araddr;
   logic               arready;
   logic               rvalid;
   logic [31:0]        rdata;
   logic [1:0]         rresp;
   logic               rready;

   // One entry per parsed test line
   byte         op_q [$];
   logic [63:0] a_q  [$];
   logic [63:0] b_q  [$];
   logic [63:0] c_q  [$];
   logic [63:0] d_q  [$];
   int          wd_clocks;
   bit          load_done;
   int          bad_lines;
   int          fails;

   cl_glue_top #(
      .STAT_STAGES (STAGES),
      .CL_ID0      (TEST_ID0),
      .CL_ID1      (TEST_ID1)
   ) dut_i (.*);

   tb_checker #(.STAT_STAGES(STAGES)) chk_i (.*);

   bind cl_glue_top cl_glue_props #(.STAT_STAGES(STAT_STAGES)) props_i (
      .clk_main_a0 (clk_main_a0),
      .sync_rst_n  (sync_rst_n),
      .awvalid     (awvalid),
      .awready     (awready),
      .wvalid      (wvalid),
      .wready      (wready),
      .bvalid      (bvalid),
      .bready      (bready),
      .bresp       (bresp),
      .arvalid     (arvalid),
      .arready     (arready),
      .rvalid      (rvalid),
      .rready      (rready),
      .rdata       (rdata),
      .rresp       (rresp),
      .stat_req    (stat_req),
      .stat_req_q  (stat_req_q)
   );

   initial
   begin
      clk_main_a0 = 1'b0;
      forever #(CLK_PERIOD / 2) clk_main_a0 = ~clk_main_a0;
   end

   // Watchdog budget scales with the number of data lines
   initial
   begin
      wait (load_done);
      #(wd_clocks * CLK_PERIOD);
      $display("Timeout: run did not finish within %0d clocks", wd_clocks);
      $display("** FAIL **");
      $finish;
   end

   // ------------------------------------------------
   // Data file reader
   // ------------------------------------------------
   function automatic bit load_testdata();
      int          fd;
      string       line;
      int          fields;
      logic [63:0] a;
      logic [63:0] b;
      logic [63:0] c;
      logic [63:0] d;
      fd = $fopen("tb/testdata.txt", "r");
      if (fd == 0)
      begin
         $display("Cannot open tb/testdata.txt");
         return 1'b0;
      end
      while ($fgets(line, fd) != 0)
      begin
         if ((line.len() < 3) || (line.getc(0) == "#"))
            continue;                                  // Blank or comment
         fields = $sscanf(line.substr(1, line.len() - 1), "%h %h %h %h", a, b, c, d);
         if (fields != 4)
         begin
            $display("Malformed test data line: %s", line);
            bad_lines++;
            continue;
         end
         op_q.push_back(line.getc(0));
         a_q.push_back(a);
         b_q.push_back(b);
         c_q.push_back(c);
         d_q.push_back(d);
      end
      $fclose(fd);
      if (op_q.size() == 0)
         $display("No operations found in tb/testdata.txt");
      return (op_q.size() != 0);
   endfunction

   // ------------------------------------------------
   // OCL transactions with random stalls on b and r
   // ------------------------------------------------
   task automatic ocl_write(input logic [31:0] addr, input logic [31:0] data,
                            input logic [3:0] strb, input logic [1:0] exp_resp);
      int stall;
      awaddr  <= addr;
      wdata   <= data;
      wstrb   <= strb;
      awvalid <= 1'b1;
      wvalid  <= 1'b1;
      chk_i.expect_write(exp_resp);
      do @(posedge clk_main_a0); while (!(awready && wready));
      awvalid <= 1'b0;
      wvalid  <= 1'b0;
      stall   = int'($urandom % 4);
      repeat (stall) @(posedge clk_main_a0);           // Hold off bready
      bready <= 1'b1;
      do @(posedge clk_main_a0); while (!bvalid);
      bready <= 1'b0;
   endtask

   task automatic ocl_read(input logic [31:0] addr, input logic [31:0] exp_data,
                           input logic [1:0] exp_resp);
      int stall;
      araddr  <= addr;
      arvalid <= 1'b1;
      chk_i.expect_read(exp_data, exp_resp);
      do @(posedge clk_main_a0); while (!arready);
      arvalid <= 1'b0;
      stall   = int'($urandom % 4);
      repeat (stall) @(posedge clk_main_a0);           // Hold off rready
      rready <= 1'b1;
      do @(posedge clk_main_a0); while (!rvalid);
      rready <= 1'b0;
   endtask

   task automatic run_line(input byte op, input logic [63:0] a, input logic [63:0] b,
                           input logic [63:0] c, input logic [63:0] d);
      case (op)
         "W" : ocl_write(a[31:0], b[31:0], c[3:0], d[1:0]);
         "R" : ocl_read(a[31:0], b[31:0], c[1:0]);
         "F" :
         begin
            sh_cl_flr_assert <= a[0];
            repeat (int'(b[15:0]) + 1) @(posedge clk_main_a0);
         end
         "D" :
         begin
            ddr_is_ready <= a[NUM_DDR-1:0];
            repeat (int'(b[15:0]) + 1) @(posedge clk_main_a0);
         end
         "S" :
         begin
            stat_req <= a[41:0];                       // One word per clock
            stat_rsp <= b[40:0];
            repeat (int'(c[15:0]) + 1) @(posedge clk_main_a0);
         end
         default :
         begin
            $display("Unknown opcode %c in test data", op);
            bad_lines++;
         end
      endcase
   endtask

   // ------------------------------------------------
   // Main sequence
   // ------------------------------------------------
   initial
   begin
      void'($urandom(74155));
      sync_rst_n       <= 1'b0;
      sh_cl_flr_assert <= 1'b0;
      ddr_is_ready     <= '0;
      stat_req         <= '0;
      stat_rsp         <= '0;
      awvalid          <= 1'b0;
      awaddr           <= '0;
      wvalid           <= 1'b0;
      wdata            <= '0;
      wstrb            <= '0;
      bready           <= 1'b0;
      arvalid          <= 1'b0;
      araddr           <= '0;
      rready           <= 1'b0;
      if (!load_testdata())
      begin
         $display("** FAIL **");
         $finish;
      end
      else
      begin
         wd_clocks = op_q.size() * 40 + 200;
         load_done = 1'b1;
         repeat (5) @(posedge clk_main_a0);
         sync_rst_n <= 1'b1;
         foreach (op_q[i])
            run_line(op_q[i], a_q[i], b_q[i], c_q[i], d_q[i]);
         repeat (STAGES + 4) @(posedge clk_main_a0);  // Let pipes drain
         fails = chk_i.err_count + dut_i.props_i.fail_count + chk_i.outstanding() + bad_lines;
         $display("Checks: %0d, checker errors: %0d, assertion failures: %0d, pending: %0d",
                  chk_i.check_count, chk_i.err_count, dut_i.props_i.fail_count,
                  chk_i.outstanding());
         if (fails == 0)
            $display("** PASS **");
         else
            $display("** FAIL **");
         $finish;
      end
   end

endmodule

//--- tb/testdata.txt
# Columns: op a b c d, values in hex
# W addr wdata wstrb bresp | R addr rdata rresp 0 | F level hold 0 0 | D ready idle 0 0 | S req rsp idle 0
# IDs and unknown offsets
R 00 F0101D0F 0 0
R 04 1D51FEDC 0 0
R 40 00000000 2 0
R 18 00000000 2 0
R 10 00000000 0 0
# Scratch with byte strobes, read-only offsets
W 14 11223344 F 0
R 14 11223344 0 0
W 14 AABBCCDD 5 0
R 14 11BB33DD 0 0
W 14 99887766 A 0
R 14 99BB77DD 0 0
W 00 DEADBEEF F 2
R 00 F0101D0F 0 0
W 08 12345678 F 2
W 10 00000001 F 2
W 14 00000000 0 0
R 14 99BB77DD 0 0
# DDR ready
D 5 4 0 0
R 08 00000005 0 0
D F 4 0 0
R 08 0000000F 0 0
# FLR raise and drop three times
F 1 6 0 0
F 0 4 0 0
F 1 5 0 0
F 0 4 0 0
F 1 3 0 0
R 08 0000010F 0 0
F 0 4 0 0
R 08 0000000F 0 0
R 0C 00000003 0 0
# Stats pipes, back to back then flush
S 2100000CAFE 10000000000 0 0
S 12000000000 00312345678 0 0
S 3FF89ABCDEF 1A5DEADBEEF 0 0
S 05500000001 17F00000002 0 0
S 00000000000 00000000000 8 0
R 10 00000003 0 0

//--- flist.f
design/cl_glue_pkg.sv
design/status_sync.sv
design/stat_pipe.sv
design/ocl_regs.sv
design/cl_glue_top.sv
tb/cl_glue_props.sv
tb/tb_checker.sv
tb/tb_top.sv

//--- Makefile
# Verilator build and run for the shell glue testbench

TOP       ?= tb_top
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+1000

SHELL       := /bin/bash
.SHELLFLAGS := -o pipefail -c

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) 2>&1 | tee $(LOG)
	@if grep -qF '** FAIL **' $(LOG); then echo "Simulation failed, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
